// File: dv/execModel.svh
`ifndef EXEC_MODEL_SVH
`define EXEC_MODEL_SVH

// Instruction kinds as the model sees them
localparam int kindBubble = 0;
localparam int kindRegAlu = 1;
localparam int kindImmAlu = 2;
localparam int kindSavf = 3;
localparam int kindMove = 4;
localparam int kindLoad = 5;
localparam int kindStore = 6;
localparam int kindBranch = 7;

function automatic execPkg::word_t extendImm(execPkg::imm_t v);
    return 32'(v);  // Signed source, so the cast sign-extends
endfunction

function automatic logic isAluCode(execPkg::aluOp_e op);
    return op inside {execPkg::opAdd, execPkg::opSub, execPkg::opAnd, execPkg::opOr,
        execPkg::opXor, execPkg::opAdds, execPkg::opSubs, execPkg::opAnds,
        execPkg::opOrs, execPkg::opXors};
endfunction

function automatic int kindOf(execPkg::execInstr_t i);
    case (i.cls)
        execPkg::clsDataReg:
            if (isAluCode(i.aluOp) || i.aluOp == execPkg::opNot) return kindRegAlu;
        execPkg::clsDataImm:
            if (!i.special && i.movOp != execPkg::movNone) return kindMove;
            else if (i.special && isAluCode(i.aluOp)) return kindImmAlu;
            else if (i.special && i.aluOp == execPkg::opSavf) return kindSavf;
        execPkg::clsMemory: return i.special ? kindStore : kindLoad;
        default: return kindBranch;
    endcase
    return kindBubble;
endfunction

function automatic execPkg::regReadReq_t readIndices(execPkg::execInstr_t i);
    execPkg::regReadReq_t r;
    int k;
    r = '0;
    k = kindOf(i);
    if (k inside {kindRegAlu, kindImmAlu, kindSavf, kindLoad, kindStore}) r.first = i.src1;
    if (k == kindRegAlu && i.aluOp != execPkg::opNot) r.sec = i.src2;
    if (k == kindStore) r.dest = i.dest;  // Store data
    if (k == kindMove && (i.movOp inside {execPkg::movMovt, execPkg::movMovf})) r.dest = i.dest;
    if (k == kindMove && (i.movOp inside {execPkg::movLsl, execPkg::movLsr})) r.first = i.src1;
    if (k == kindBranch && i.brCond == execPkg::brBr) r.first = i.src1;
    return r;
endfunction

function automatic execPkg::word_t operandB(execPkg::execInstr_t i, execPkg::regReadData_t d);
    return (i.cls == execPkg::clsDataImm) ? extendImm(i.imm) : d.sec;
endfunction

function automatic execPkg::word_t aluValue(execPkg::execInstr_t i, execPkg::regReadData_t d);
    execPkg::word_t b;
    b = operandB(i, d);
    case (i.aluOp)
        execPkg::opAdd, execPkg::opAdds: return d.first + b;
        execPkg::opSub, execPkg::opSubs: return d.first - b;
        execPkg::opAnd, execPkg::opAnds: return d.first & b;
        execPkg::opOr, execPkg::opOrs: return d.first | b;
        execPkg::opXor, execPkg::opXors: return d.first ^ b;
        execPkg::opNot: return ~d.first;
        default: return '0;
    endcase
endfunction

function automatic execPkg::word_t moveValue(execPkg::execInstr_t i, execPkg::regReadData_t d,
        execPkg::flags_t f);
    int amt;
    amt = {16'd0, i.imm};  // Whole immediate, unsigned
    case (i.movOp)
        execPkg::movMov: return {16'd0, i.imm};
        execPkg::movMovt: return {i.imm, d.dest[15:0]};
        execPkg::movSet: return 32'hffff_ffff;
        execPkg::movLsl: return (amt >= 32) ? 32'd0 : d.first << amt;
        execPkg::movLsr: return (amt >= 32) ? 32'd0 : d.first >> amt;
        execPkg::movMovf: return {28'd0, f};
        default: return '0;
    endcase
endfunction

function automatic execPkg::regWrite_t writeResult(execPkg::execInstr_t i,
        execPkg::regReadData_t d, execPkg::word_t memIn, execPkg::flags_t f);
    execPkg::regWrite_t w;
    int k;
    w = '0;
    k = kindOf(i);
    w.en = k inside {kindRegAlu, kindImmAlu, kindSavf, kindMove, kindLoad};
    case (k)
        kindRegAlu, kindImmAlu: w.data = aluValue(i, d);
        kindMove: w.data = moveValue(i, d, f);
        kindLoad: w.data = memIn;
        kindSavf: w.data = {28'd0, d.first[3:0]};
        default: ;
    endcase
    return w;
endfunction

function automatic execPkg::memReq_t memRequest(execPkg::execInstr_t i,
        execPkg::regReadData_t d);
    execPkg::memReq_t m;
    int k;
    m = '0;
    k = kindOf(i);
    m.read = (k == kindLoad);
    m.write = (k == kindStore);
    if (m.read || m.write) m.addr = d.first + extendImm(i.imm);
    if (m.write) m.data = d.dest;
    return m;
endfunction

function automatic execPkg::word_t targetAddress(execPkg::execInstr_t i,
        execPkg::regReadData_t d);
    return (kindOf(i) == kindBranch) ? d.first + extendImm(i.imm) : 32'd0;
endfunction

function automatic logic branchOutcome(execPkg::execInstr_t i, execPkg::flags_t f);
    logic hiCond;
    logic geCond;
    hiCond = f.c && !f.z;
    geCond = (f.n == f.v);
    if (kindOf(i) != kindBranch) return 1'b0;
    case (i.brCond)
        execPkg::brEq: return f.z;
        execPkg::brNe: return !f.z;
        execPkg::brBr: return 1'b1;
        execPkg::brLo: return !f.c;
        execPkg::brMi: return f.n;
        execPkg::brPl: return !f.n;
        execPkg::brVs: return f.v;
        execPkg::brVc: return !f.v;
        execPkg::brHi: return hiCond;
        execPkg::brLs: return !hiCond;
        execPkg::brGe: return geCond;
        execPkg::brLt: return !geCond;
        execPkg::brGt: return !f.z && geCond;
        execPkg::brLe: return !(!f.z && geCond);
        default: return 1'b0;
    endcase
endfunction

function automatic execPkg::flags_t nextFlags(execPkg::execInstr_t i,
        execPkg::regReadData_t d, execPkg::flags_t f);
    execPkg::flags_t nf;
    execPkg::word_t a;
    execPkg::word_t b;
    execPkg::word_t res;
    int k;
    nf = f;
    k = kindOf(i);
    if (k == kindSavf) return execPkg::flags_t'(d.first[3:0]);
    if (k != kindRegAlu && k != kindImmAlu) return f;
    a = d.first;
    b = operandB(i, d);
    res = aluValue(i, d);
    if (i.aluOp inside {execPkg::opAdds, execPkg::opSubs, execPkg::opAnds,
            execPkg::opOrs, execPkg::opXors}) begin
        nf.n = res[31];
        nf.z = (res == 32'd0);
    end
    if (i.aluOp == execPkg::opAdds) begin
        nf.c = (res < a);  // Wrapped past the top
        nf.v = (a[31] == b[31]) && (res[31] != a[31]);
    end else if (i.aluOp == execPkg::opSubs) begin
        nf.c = (a >= b);  // No borrow
        nf.v = (a[31] != b[31]) && (res[31] != a[31]);
    end
    return nf;
endfunction

`endif

// File: dv/tbExecute.sv
`timescale 1ns/1ps
`default_nettype none

module tbExecute;

    localparam int resetCycles = 3;
    localparam int totalInstrs = 1 + 200 + 200 + 32 + 150 + 150;
    localparam int cycleLimit = (totalInstrs * 3) / 2 + resetCycles;
    localparam logic [3:0] regAluCodes [11] = '{4'h1, 4'h2, 4'h3, 4'h4, 4'h5, 4'h6,
        4'h9, 4'hA, 4'hB, 4'hC, 4'hD};

    logic clk;
    logic rst;
    execPkg::execInstr_t instr;
    execPkg::regReadData_t readData;
    execPkg::word_t memoryDataIn;
    execPkg::regReadReq_t readReq;
    execPkg::regWrite_t writeBack;
    execPkg::memReq_t mem;
    logic branchTaken;
    execPkg::word_t branchTarget;
    execPkg::flags_t flags;

    execPkg::word_t regs [16];
    execPkg::flags_t modelFlags;  // Value after the next edge is applied at each check
    logic [31:0] lcgState;
    int errors;
    int checks;
    int cycles = 0;

    `include "execModel.svh"

    executeStage dut (
        .clk(clk),
        .rst(rst),
        .instr(instr),
        .readData(readData),
        .memoryDataIn(memoryDataIn),
        .readReq(readReq),
        .writeBack(writeBack),
        .mem(mem),
        .branchTaken(branchTaken),
        .branchTarget(branchTarget),
        .flags(flags)
    );

    always #4 clk = ~clk;

    // Register file answers in the same cycle
    always_comb begin
        readData.dest = regs[readReq.dest];
        readData.first = regs[readReq.first];
        readData.sec = regs[readReq.sec];
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= cycleLimit) begin
            $display("Timeout: run stopped after %0d cycles", cycles);
            $display("Checks failed");
            $finish;
        end
    end

    function automatic logic [31:0] nextRandom();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return {lcgState[15:0], lcgState[31:16]};  // Better bits at the bottom
    endfunction

    function automatic int pick(int n);
        return int'(nextRandom() % n);
    endfunction

    function automatic execPkg::execInstr_t randomFields();
        execPkg::execInstr_t i;
        logic [31:0] r;
        r = nextRandom();
        i.cls = execPkg::instrClass_e'(r[1:0]);
        i.special = r[2];
        i.aluOp = execPkg::aluOp_e'(r[6:3]);
        i.movOp = execPkg::movOp_e'(r[9:7]);
        i.brCond = execPkg::brCond_e'(r[13:10]);
        i.dest = r[17:14];
        i.src1 = r[21:18];
        i.src2 = r[25:22];
        r = nextRandom();
        i.imm = r[16] ? execPkg::imm_t'({10'd0, r[5:0]}) : r[15:0];  // Small shifts too
        return i;
    endfunction

    task automatic checkValue(input string name, input logic [63:0] got,
            input logic [63:0] want);
        checks++;
        assert (got === want) else begin
            errors++;
            $display("mismatch %s expected %h actual %h", name, want, got);
        end
    endtask

    task automatic runInstr(input execPkg::execInstr_t next);
        execPkg::word_t fresh [16];
        execPkg::regReadReq_t req;
        execPkg::regReadData_t d;
        execPkg::regWrite_t w;
        execPkg::memReq_t m;
        int k;
        for (k = 0; k < 16; k++) begin
            fresh[k] = nextRandom();
        end
        @(posedge clk);
        instr <= next;
        regs <= fresh;
        memoryDataIn <= nextRandom();
        @(negedge clk);
        req = readIndices(next);
        d.dest = regs[req.dest];
        d.first = regs[req.first];
        d.sec = regs[req.sec];
        w = writeResult(next, d, memoryDataIn, modelFlags);
        m = memRequest(next, d);
        checkValue("flags", 64'(flags), 64'(modelFlags));
        checkValue("readReq", 64'(readReq), 64'(req));
        checkValue("writeBack.en", 64'(writeBack.en), 64'(w.en));
        checkValue("writeBack.data", 64'(writeBack.data), 64'(w.data));
        checkValue("mem.read", 64'(mem.read), 64'(m.read));
        checkValue("mem.write", 64'(mem.write), 64'(m.write));
        checkValue("mem.addr", 64'(mem.addr), 64'(m.addr));
        checkValue("mem.data", 64'(mem.data), 64'(m.data));
        checkValue("branchTaken", 64'(branchTaken), 64'(branchOutcome(next, modelFlags)));
        checkValue("branchTarget", 64'(branchTarget), 64'(targetAddress(next, d)));
        modelFlags = nextFlags(next, d, modelFlags);
    endtask

    task automatic reportTest(input string name, input int startErrors);
        $display("test %s finished with %0d errors", name, errors - startErrors);
    endtask

    initial begin
        execPkg::execInstr_t i;
        execPkg::word_t saved;
        int startErrors;
        int n;
        clk = 1'b0;
        rst = 1'b1;
        instr = '0;
        instr.cls = execPkg::clsDataReg;  // opNone, a bubble
        memoryDataIn = '0;
        regs = '{default: '0};
        modelFlags = '0;
        lcgState = 32'd24142;
        errors = 0;
        checks = 0;
        repeat (resetCycles) @(posedge clk);
        rst <= 1'b0;

        startErrors = errors;
        i = '0;
        i.cls = execPkg::clsDataReg;
        runInstr(i);
        checkValue("flags", 64'(flags), 64'd0);
        checkValue("writeBack.en", 64'(writeBack.en), 64'd0);
        checkValue("branchTaken", 64'(branchTaken), 64'd0);
        reportTest("after reset", startErrors);

        startErrors = errors;
        for (n = 0; n < 200; n++) begin
            i = randomFields();
            i.cls = execPkg::clsDataReg;
            i.aluOp = execPkg::aluOp_e'(regAluCodes[pick(11)]);
            runInstr(i);
        end
        reportTest("register ops", startErrors);

        startErrors = errors;
        for (n = 0; n < 200; n++) begin
            i = randomFields();
            i.cls = execPkg::clsDataImm;  // Random aluOp and movOp, bubbles included
            runInstr(i);
        end
        reportTest("immediate ops", startErrors);

        startErrors = errors;
        for (n = 0; n < 8; n++) begin
            i = randomFields();
            i.cls = execPkg::clsDataImm;
            i.special = 1'b1;
            i.aluOp = execPkg::opSavf;
            runInstr(i);
            saved = {28'd0, regs[i.src1][3:0]};
            i.cls = execPkg::clsDataReg;
            i.aluOp = execPkg::opAdd;  // No flag update
            runInstr(i);
            i.cls = execPkg::clsDataImm;
            i.special = 1'b0;
            i.movOp = execPkg::movMov;
            runInstr(i);
            i.movOp = execPkg::movMovf;
            runInstr(i);
            checkValue("writeBack.data", 64'(writeBack.data), 64'(saved));
            checkValue("flags", 64'(flags), 64'(saved));
        end
        reportTest("flag save and restore", startErrors);

        startErrors = errors;
        for (n = 0; n < 75; n++) begin
            i = randomFields();
            i.cls = execPkg::clsDataReg;
            i.aluOp = execPkg::aluOp_e'(4'(9 + pick(5)));  // Flag-setting codes
            runInstr(i);
            i = randomFields();
            i.cls = execPkg::clsBranch;
            runInstr(i);
        end
        reportTest("branches", startErrors);

        startErrors = errors;
        for (n = 0; n < 150; n++) begin
            i = randomFields();
            i.cls = execPkg::clsMemory;
            runInstr(i);
        end
        reportTest("loads and stores", startErrors);

        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: hdl/addressUnit.sv
`timescale 1ns/1ps
`default_nettype none

module addressUnit (
    input wire execPkg::execCtrl_t ctrl,
    input wire execPkg::imm_t imm,
    input wire execPkg::regReadData_t readData,
    output execPkg::memReq_t mem,
    output execPkg::word_t branchTarget
);

    execPkg::word_t effAddr;
    logic memAccess;

    // Base plus offset, shared by memory and BR
    assign effAddr = readData.first + execPkg::signExtend(imm);
    assign memAccess = ctrl.memRead | ctrl.memWrite;

    assign mem.read = ctrl.memRead;
    assign mem.write = ctrl.memWrite;
    assign mem.addr = memAccess ? effAddr : '0;
    assign mem.data = ctrl.memWrite ? readData.dest : '0;
    assign branchTarget = ctrl.isBranch ? effAddr : '0;

    always_comb begin
        assert final (!(mem.read && mem.write))
            else $error("addressUnit: read and write requested together");
    end

endmodule

`default_nettype wire

// File: hdl/branchResolve.sv
`timescale 1ns/1ps
`default_nettype none

module branchResolve (
    input wire execPkg::execCtrl_t ctrl,
    input wire execPkg::brCond_e brCond,
    input wire execPkg::flags_t flags,
    output logic branchTaken
);

    logic hi;
    logic ge;
    logic gt;
    logic condMet;

    assign hi = flags.c & ~flags.z;  // Unsigned higher
    assign ge = (flags.n == flags.v);
    assign gt = ~flags.z & ge;

    always_comb begin
        case (brCond)
            execPkg::brEq: condMet = flags.z;
            execPkg::brNe: condMet = ~flags.z;
            execPkg::brBr: condMet = 1'b1;  // Indirect, unconditional
            execPkg::brLo: condMet = ~flags.c;
            execPkg::brMi: condMet = flags.n;
            execPkg::brPl: condMet = ~flags.n;
            execPkg::brVs: condMet = flags.v;
            execPkg::brVc: condMet = ~flags.v;
            execPkg::brHi: condMet = hi;
            execPkg::brLs: condMet = ~hi;
            execPkg::brGe: condMet = ge;
            execPkg::brLt: condMet = ~ge;
            execPkg::brGt: condMet = gt;
            execPkg::brLe: condMet = ~gt;
            default: condMet = 1'b0;  // Codes 14 and 15
        endcase
    end

    assign branchTaken = ctrl.isBranch & condMet;

endmodule

`default_nettype wire

// File: hdl/execDecode.sv
`timescale 1ns/1ps
`default_nettype none

module execDecode (
    input wire execPkg::execInstr_t instr,
    output execPkg::regReadReq_t readReq,
    output execPkg::execCtrl_t ctrl
);

    always_comb begin
        readReq = '0;
        ctrl.resultSrc = execPkg::srcNone;
        ctrl.flagUpd = execPkg::updNone;
        ctrl.aluOp = execPkg::opNone;
        ctrl.movOp = execPkg::movNone;
        ctrl.useImm = 1'b0;
        ctrl.isBranch = 1'b0;
        ctrl.memRead = 1'b0;
        ctrl.memWrite = 1'b0;

        case (instr.cls)
            execPkg::clsDataReg: begin
                case (instr.aluOp)
                    execPkg::opAdd, execPkg::opSub, execPkg::opAnd, execPkg::opOr,
                    execPkg::opXor, execPkg::opAdds, execPkg::opSubs, execPkg::opAnds,
                    execPkg::opOrs, execPkg::opXors: begin
                        readReq.first = instr.src1;
                        readReq.sec = instr.src2;
                        ctrl.resultSrc = execPkg::srcAlu;
                        ctrl.aluOp = instr.aluOp;
                    end
                    execPkg::opNot: begin  // Single operand
                        readReq.first = instr.src1;
                        ctrl.resultSrc = execPkg::srcAlu;
                        ctrl.aluOp = instr.aluOp;
                    end
                    default: ;  // Bubble
                endcase
            end

            execPkg::clsDataImm: begin
                if (instr.special) begin
                    case (instr.aluOp)
                        execPkg::opAdd, execPkg::opSub, execPkg::opAnd, execPkg::opOr,
                        execPkg::opXor, execPkg::opAdds, execPkg::opSubs, execPkg::opAnds,
                        execPkg::opOrs, execPkg::opXors: begin
                            readReq.first = instr.src1;
                            ctrl.resultSrc = execPkg::srcAlu;
                            ctrl.aluOp = instr.aluOp;
                            ctrl.useImm = 1'b1;
                        end
                        execPkg::opSavf: begin
                            readReq.first = instr.src1;
                            ctrl.resultSrc = execPkg::srcFlags;
                            ctrl.flagUpd = execPkg::updLoad;
                        end
                        default: ;
                    endcase
                end else begin
                    // Moves and shifts
                    case (instr.movOp)
                        execPkg::movMov, execPkg::movClr, execPkg::movSet: ;
                        execPkg::movMovt, execPkg::movMovf: readReq.dest = instr.dest;
                        execPkg::movLsl, execPkg::movLsr: readReq.first = instr.src1;
                        default: ;
                    endcase
                    if (instr.movOp != execPkg::movNone) begin
                        ctrl.resultSrc = execPkg::srcMove;
                        ctrl.movOp = instr.movOp;
                    end
                end
            end

            execPkg::clsMemory: begin
                readReq.first = instr.src1;  // Base
                if (instr.special) begin
                    readReq.dest = instr.dest;  // Store data
                    ctrl.memWrite = 1'b1;
                end else begin
                    ctrl.memRead = 1'b1;
                    ctrl.resultSrc = execPkg::srcLoad;
                end
            end

            default: begin
                ctrl.isBranch = 1'b1;
                if (instr.brCond == execPkg::brBr) begin
                    readReq.first = instr.src1;
                end
            end
        endcase

        // Flag-setting variants only
        if (ctrl.resultSrc == execPkg::srcAlu) begin
            case (ctrl.aluOp)
                execPkg::opAdds, execPkg::opSubs: ctrl.flagUpd = execPkg::updNzcv;
                execPkg::opAnds, execPkg::opOrs, execPkg::opXors: ctrl.flagUpd = execPkg::updNz;
                default: ;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: hdl/execPkg.sv
`default_nettype none

package execPkg;

    typedef logic [31:0] word_t;        // Data word and address
    typedef logic [3:0] regIdx_t;
    typedef logic signed [15:0] imm_t;  // Sign-extended for arithmetic and addresses

    // NZCV, n in the top bit
    typedef struct packed {
        logic n;
        logic z;
        logic c;
        logic v;
    } flags_t;

    typedef enum logic [1:0] {
        clsDataImm = 2'b00,
        clsDataReg = 2'b01,
        clsMemory  = 2'b10,
        clsBranch  = 2'b11
    } instrClass_e;

    typedef enum logic [3:0] {
        opNone   = 4'b0000,
        opAdd    = 4'b0001,
        opSub    = 4'b0010,
        opAnd    = 4'b0011,
        opOr     = 4'b0100,
        opXor    = 4'b0101,
        opNot    = 4'b0110,  // Register class only
        opNoneHi = 4'b1000,  // Retired code, no effect
        opAdds   = 4'b1001,
        opSubs   = 4'b1010,
        opAnds   = 4'b1011,
        opOrs    = 4'b1100,
        opXors   = 4'b1101,
        opSavf   = 4'b1110   // Immediate class only
    } aluOp_e;

    typedef enum logic [2:0] {
        movMov  = 3'd0,
        movMovt = 3'd1,
        movClr  = 3'd2,
        movSet  = 3'd3,
        movLsl  = 3'd4,
        movLsr  = 3'd5,
        movMovf = 3'd6,
        movNone = 3'd7
    } movOp_e;

    typedef enum logic [3:0] {
        brEq, brNe, brBr, brLo, brMi, brPl, brVs, brVc,
        brHi, brLs, brGe, brLt, brGt, brLe, brNv0, brNv1
    } brCond_e;

    typedef enum logic [2:0] {srcNone, srcAlu, srcMove, srcLoad, srcFlags} resultSrc_e;
    typedef enum logic [1:0] {updNone, updNz, updNzcv, updLoad} flagUpd_e;

    typedef struct packed {
        instrClass_e cls;
        logic special;  // Store on memory class, ALU over move on immediate class
        aluOp_e aluOp;
        movOp_e movOp;
        brCond_e brCond;
        regIdx_t dest;
        regIdx_t src1;
        regIdx_t src2;
        imm_t imm;
    } execInstr_t;

    typedef struct packed {
        resultSrc_e resultSrc;
        flagUpd_e flagUpd;
        aluOp_e aluOp;
        movOp_e movOp;
        logic useImm;   // Operand B from the immediate
        logic isBranch;
        logic memRead;
        logic memWrite;
    } execCtrl_t;

    typedef struct packed {
        regIdx_t dest;
        regIdx_t first;
        regIdx_t sec;
    } regReadReq_t;

    typedef struct packed {
        word_t dest;
        word_t first;
        word_t sec;
    } regReadData_t;

    typedef struct packed {
        logic en;
        word_t data;
    } regWrite_t;

    typedef struct packed {
        logic read;
        logic write;
        word_t addr;
        word_t data;
    } memReq_t;

    function automatic word_t signExtend(imm_t imm);
        return {{16{imm[15]}}, imm};
    endfunction

endpackage

`default_nettype wire

// File: hdl/executeStage.sv
`timescale 1ns/1ps
`default_nettype none

module executeStage (
    input wire clk,
    input wire rst,
    input wire execPkg::execInstr_t instr,
    input wire execPkg::regReadData_t readData,
    input wire execPkg::word_t memoryDataIn,
    output execPkg::regReadReq_t readReq,
    output execPkg::regWrite_t writeBack,
    output execPkg::memReq_t mem,
    output logic branchTaken,
    output execPkg::word_t branchTarget,
    output execPkg::flags_t flags
);

    execPkg::execCtrl_t ctrl;
    execPkg::flags_t newFlags;

    execDecode uDecode (
        .instr(instr),
        .readReq(readReq),
        .ctrl(ctrl)
    );

    integerUnit uInteger (
        .ctrl(ctrl),
        .imm(instr.imm),
        .readData(readData),
        .memoryDataIn(memoryDataIn),
        .flags(flags),
        .writeBack(writeBack),
        .newFlags(newFlags)
    );

    // Registered NZCV, seen by the next instruction
    flagRegister uFlags (
        .clk(clk),
        .rst(rst),
        .ctrl(ctrl),
        .newFlags(newFlags),
        .flags(flags)
    );

    branchResolve uBranch (
        .ctrl(ctrl),
        .brCond(instr.brCond),
        .flags(flags),
        .branchTaken(branchTaken)
    );

    addressUnit uAddress (
        .ctrl(ctrl),
        .imm(instr.imm),
        .readData(readData),
        .mem(mem),
        .branchTarget(branchTarget)
    );

endmodule

`default_nettype wire

// File: hdl/flagRegister.sv
`timescale 1ns/1ps
`default_nettype none

module flagRegister (
    input wire clk,
    input wire rst,
    input wire execPkg::execCtrl_t ctrl,
    input wire execPkg::flags_t newFlags,
    output execPkg::flags_t flags
);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            flags <= '0;
        end else begin
            case (ctrl.flagUpd)
                execPkg::updNz: begin  // Logic ops
                    flags.n <= newFlags.n;
                    flags.z <= newFlags.z;
                end
                execPkg::updNzcv, execPkg::updLoad: flags <= newFlags;
                default: ;
            endcase
        end
    end

    assert property (@(posedge clk) disable iff (rst)
        ctrl.flagUpd == execPkg::updNone |=> $stable(flags))
        else $error("flagRegister: flags changed with no update");

endmodule

`default_nettype wire

// File: hdl/integerUnit.sv
`timescale 1ns/1ps
`default_nettype none

module integerUnit (
    input wire execPkg::execCtrl_t ctrl,
    input wire execPkg::imm_t imm,
    input wire execPkg::regReadData_t readData,
    input wire execPkg::word_t memoryDataIn,
    input wire execPkg::flags_t flags,
    output execPkg::regWrite_t writeBack,
    output execPkg::flags_t newFlags
);

    execPkg::word_t opB;
    execPkg::word_t aluRes;
    execPkg::word_t moveRes;
    logic [32:0] sum;
    logic [32:0] diff;
    logic aSign;

    assign aSign = readData.first[31];

    always_comb begin
        opB = ctrl.useImm ? execPkg::signExtend(imm) : readData.sec;
        sum = {1'b0, readData.first} + {1'b0, opB};
        diff = {1'b0, readData.first} - {1'b0, opB};  // Top bit is the borrow

        case (ctrl.aluOp)
            execPkg::opAdd, execPkg::opAdds: aluRes = sum[31:0];
            execPkg::opSub, execPkg::opSubs: aluRes = diff[31:0];
            execPkg::opAnd, execPkg::opAnds: aluRes = readData.first & opB;
            execPkg::opOr, execPkg::opOrs: aluRes = readData.first | opB;
            execPkg::opXor, execPkg::opXors: aluRes = readData.first ^ opB;
            execPkg::opNot: aluRes = ~readData.first;
            default: aluRes = '0;
        endcase
    end

    always_comb begin
        case (ctrl.movOp)
            execPkg::movMov: moveRes = {16'h0000, imm};
            execPkg::movMovt: moveRes = {imm, readData.dest[15:0]};  // Keep low half
            execPkg::movSet: moveRes = '1;
            // Full immediate as amount, 32 and up clears
            execPkg::movLsl: moveRes = readData.first << $unsigned(imm);
            execPkg::movLsr: moveRes = readData.first >> $unsigned(imm);
            execPkg::movMovf: moveRes = {28'h0000000, flags};
            default: moveRes = '0;  // CLR
        endcase
    end

    always_comb begin
        case (ctrl.resultSrc)
            execPkg::srcAlu: writeBack.data = aluRes;
            execPkg::srcMove: writeBack.data = moveRes;
            execPkg::srcLoad: writeBack.data = memoryDataIn;
            execPkg::srcFlags: writeBack.data = {28'h0000000, readData.first[3:0]};
            default: writeBack.data = '0;
        endcase
        writeBack.en = (ctrl.resultSrc != execPkg::srcNone);
    end

    always_comb begin
        newFlags.n = aluRes[31];
        newFlags.z = (aluRes == '0);
        newFlags.c = flags.c;  // Logic ops leave C and V
        newFlags.v = flags.v;
        case (ctrl.aluOp)
            execPkg::opAdds: begin
                newFlags.c = sum[32];
                newFlags.v = (aSign == opB[31]) && (sum[31] != aSign);
            end
            execPkg::opSubs: begin
                newFlags.c = ~diff[32];  // Not borrow
                newFlags.v = (aSign != opB[31]) && (diff[31] != aSign);
            end
            default: ;
        endcase
        if (ctrl.resultSrc == execPkg::srcFlags) begin
            newFlags = readData.first[3:0];  // SAVF
        end
    end

    // Stores and branches never write back
    always_comb begin
        assert final ((writeBack.en == (ctrl.resultSrc != execPkg::srcNone))
                && !(writeBack.en && (ctrl.memWrite || ctrl.isBranch)))
            else $error("integerUnit: write-back enable inconsistent with control");
    end

endmodule

`default_nettype wire

// File: run.sh
#!/usr/bin/env bash
# Compile and run the execute stage testbench with Verilator
set -eo pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tbExecute -f src.f -Mdir obj_dir
./obj_dir/VtbExecute | tee sim.log

if grep -q "Checks failed" sim.log; then
    echo "Simulation reported failures"
    exit 1
fi
echo "Simulation finished without failures"

// File: src.f
+incdir+dv
hdl/execPkg.sv
hdl/execDecode.sv
hdl/integerUnit.sv
hdl/flagRegister.sv
hdl/branchResolve.sv
hdl/addressUnit.sv
hdl/executeStage.sv
dv/tbExecute.sv
